/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP        := tb_vga_dither_top
FILELIST   := vga_dither_top.f
BUILD_DIR  := obj_dir
PASS_MSG   := === PASS ===

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* rtl/vga_dither_24_to_12.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_dither_24_to_12
    import vga_pkg::*;
(
    input  wire    I_clk,
    input  wire    rst_n,
    input  wire    pixel_t pixel,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output rgb12_t rgb12
);

    // sync values of the previous cycle, for edge detection
    logic   prev_hsync;
    logic   prev_vsync;
    logic   hsync_rise;
    logic   vsync_rise;

    // position parity within the 2x2 matrix, and frame parity
    logic   col;
    logic   row;
    logic   frame;

    chan4_t threshold;

    // reduced channels
    chan4_t dith_r;
    chan4_t dith_g;
    chan4_t dith_b;

    assign hsync_rise = pixel.hsync && !prev_hsync;
    assign vsync_rise = pixel.vsync && !prev_vsync;

    always_comb begin
        unique case ({frame, row, col})
            // even frames
            3'b000:  threshold = 4'd15;
            3'b001:  threshold = 4'd3;
            3'b010:  threshold = 4'd7;
            3'b011:  threshold = 4'd11;
            // odd frames, matrix swapped so the pattern does not stand still
            3'b100:  threshold = 4'd11;
            3'b101:  threshold = 4'd7;
            3'b110:  threshold = 4'd3;
            default: threshold = 4'd15;
        endcase
    end

    // one ditherer per channel, same threshold for all three
    vga_dither_channel_8_to_4 dither_r_inst (
        .data      (pixel.rgb[23:16]),
        .threshold (threshold),
        .dithered  (dith_r)
    );

    vga_dither_channel_8_to_4 dither_g_inst (
        .data      (pixel.rgb[15:8]),
        .threshold (threshold),
        .dithered  (dith_g)
    );

    vga_dither_channel_8_to_4 dither_b_inst (
        .data      (pixel.rgb[7:0]),
        .threshold (threshold),
        .dithered  (dith_b)
    );

    // parity tracking
    // a vsync rise restarts the matrix and wins over everything else
    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            prev_hsync <= 1'b0;
            prev_vsync <= 1'b0;
            col        <= 1'b0;
            row        <= 1'b0;
            frame      <= 1'b0;
        end else begin
            prev_hsync <= pixel.hsync;
            prev_vsync <= pixel.vsync;
            if (vsync_rise) begin
                frame <= ~frame;
                row   <= 1'b0;
                col   <= 1'b0;
            end else begin
                // next column every pixel clock
                col <= ~col;
                // next row on each hsync pulse
                if (hsync_rise) begin
                    row <= ~row;
                end
            end
        end
    end

    // output register, syncs and de delayed to match the colour
    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            hsync <= 1'b0;
            vsync <= 1'b0;
            de    <= 1'b0;
            rgb12 <= '0;
        end else begin
            hsync <= pixel.hsync;
            vsync <= pixel.vsync;
            de    <= pixel.de;
            rgb12 <= {dith_r, dith_g, dith_b};
        end
    end

endmodule

`default_nettype wire

/* rtl/vga_dither_channel_8_to_4.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_dither_channel_8_to_4
    import vga_pkg::*;
(
    input  wire chan8_t data,
    input  wire chan4_t threshold,
    output chan4_t      dithered
);

    // the kept part and the part that would be lost
    chan4_t upper;
    chan4_t lower;
    // distance between the two nibbles
    chan4_t delta;
    logic   upper_gt_lower;
    logic   adjust;

    assign upper = data[7:4];
    assign lower = data[3:0];

    assign upper_gt_lower = (upper > lower);

    // absolute difference, always non-negative
    assign delta = upper_gt_lower ? (upper - lower) : (lower - upper);

    // a large spread pushes the output one step toward the lower nibble
    assign adjust = (delta >= threshold);

    // step down when upper is above lower, else step up
    // wraps modulo 16 in both directions
    assign dithered = !adjust        ? upper :
                      upper_gt_lower ? upper - 1'b1 :
                                       upper + 1'b1;

endmodule

`default_nettype wire

/* rtl/vga_dither_top.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_dither_top
    import vga_pkg::*;
#(
    // default mode is 640x480 at the standard porches
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire    I_clk,
    input  wire    rst_n,
    output logic   hsync,
    output logic   vsync,
    output logic   de,
    output rgb12_t rgb12
);

    // raster timing into the pattern source
    timing_t timing_bus;
    // full-colour pixels into the ditherer
    pixel_t  pixel_bus;

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) timing_inst (
        .I_clk  (I_clk),
        .rst_n  (rst_n),
        .timing (timing_bus)
    );

    // one cycle, timing to pixel
    vga_pattern_gen pattern_inst (
        .I_clk  (I_clk),
        .rst_n  (rst_n),
        .timing (timing_bus),
        .pixel  (pixel_bus)
    );

    // one cycle, pixel to pins
    vga_dither_24_to_12 dither_inst (
        .I_clk (I_clk),
        .rst_n (rst_n),
        .pixel (pixel_bus),
        .hsync (hsync),
        .vsync (vsync),
        .de    (de),
        .rgb12 (rgb12)
    );

endmodule

`default_nettype wire

/* rtl/vga_pattern_gen.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_pattern_gen
    import vga_pkg::*;
(
    input  wire     I_clk,
    input  wire     rst_n,
    input  wire     timing_t timing,
    output pixel_t  pixel
);

    // counts frame starts since reset
    frame_cnt_t frame_cnt;
    // value including the frame start seen this cycle
    frame_cnt_t frame_cnt_next;

    // pattern channels before blanking
    chan8_t     red;
    chan8_t     green;
    chan8_t     blue;
    rgb24_t     colour;

    // bump on frame_start and use the new value at once
    // so the first frame after reset carries 1
    assign frame_cnt_next = timing.frame_start ? frame_cnt + 1'b1 : frame_cnt;

    // horizontal ramp on red
    assign red   = timing.x[7:0];
    // diagonal ramp on green, wraps every 256
    assign green = timing.x[7:0] + timing.y[7:0];
    // blue steps once per frame
    assign blue  = frame_cnt_next;

    // blank outside the visible area
    assign colour = timing.de ? {red, green, blue} : '0;

    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            frame_cnt <= '0;
        end else begin
            frame_cnt <= frame_cnt_next;
        end
    end

    // one stage of latency, syncs and de travel with the colour
    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            pixel <= '0;
        end else begin
            pixel.hsync <= timing.hsync;
            pixel.vsync <= timing.vsync;
            pixel.de    <= timing.de;
            pixel.rgb   <= colour;
        end
    end

endmodule

`default_nettype wire

/* rtl/vga_pkg.sv */
`default_nettype none

package vga_pkg;

    // horizontal pixel or vertical line count
    // 12 bits covers modes well beyond 640x480
    typedef logic [11:0] coord_t;

    // one full-depth colour channel
    typedef logic [7:0] chan8_t;

    // one reduced channel as driven to the 4-bit DAC
    // the dither threshold uses the same width
    typedef logic [3:0] chan4_t;

    // red in [23:16], green in [15:8], blue in [7:0]
    typedef logic [23:0] rgb24_t;

    // red in [11:8], green in [7:4], blue in [3:0]
    typedef logic [11:0] rgb12_t;

    // frames seen by the pattern source, wraps at 256
    typedef logic [7:0] frame_cnt_t;

    // raster timing as produced by the timing generator
    // syncs are active high, x and y are meaningful while de is set
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        coord_t x;
        coord_t y;
        logic   line_start;
        logic   frame_start;
    } timing_t;

    // one full-colour pixel with the syncs that belong to it
    typedef struct packed {
        logic   hsync;
        logic   vsync;
        logic   de;
        rgb24_t rgb;
    } pixel_t;

endpackage

`default_nettype wire

/* rtl/vga_timing.sv */
`default_nettype none
`timescale 1ns/1ps

module vga_timing
    import vga_pkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int H_FRONT  = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BACK   = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  wire     I_clk,
    input  wire     rst_n,
    output timing_t timing
);

    // line layout: active, front porch, sync, back porch
    // frame layout follows the same order in lines
    localparam coord_t H_LAST   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam coord_t HS_BEGIN = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t HS_END   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t H_ACT    = coord_t'(H_ACTIVE);

    localparam coord_t V_LAST   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    localparam coord_t VS_BEGIN = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t VS_END   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);
    localparam coord_t V_ACT    = coord_t'(V_ACTIVE);

    // free-running raster position
    coord_t  h_cnt;
    coord_t  v_cnt;

    // end of line and end of frame
    logic    h_last;
    logic    v_last;

    // flags decoded from the current position, registered below
    timing_t timing_next;

    assign h_last = (h_cnt == H_LAST);
    assign v_last = (v_cnt == V_LAST);

    always_comb begin
        // hsync covers H_SYNC pixels after the front porch
        timing_next.hsync       = (h_cnt >= HS_BEGIN) && (h_cnt < HS_END);
        // vsync is decoded from the line count only
        // so it spans whole lines starting at pixel 0
        timing_next.vsync       = (v_cnt >= VS_BEGIN) && (v_cnt < VS_END);
        timing_next.de          = (h_cnt < H_ACT) && (v_cnt < V_ACT);
        timing_next.x           = h_cnt;
        timing_next.y           = v_cnt;
        timing_next.line_start  = (h_cnt == '0);
        timing_next.frame_start = (h_cnt == '0) && (v_cnt == '0);
    end

    // counters wrap at the line and frame totals
    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 1'b1;
            end
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    // output register, one cycle behind the counters
    // the first cycle out of reset therefore shows 0,0 with frame_start
    always_ff @(posedge I_clk) begin
        if (!rst_n) begin
            timing <= '0;
        end else begin
            timing <= timing_next;
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_vga_dither_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_vga_dither_top
    import vga_pkg::*;
();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_FRAMES   = 4;

    // small raster so that several frames fit in a short run
    localparam int H_ACTIVE = 16;
    localparam int H_FRONT  = 2;
    localparam int H_SYNC   = 3;
    localparam int H_BACK   = 3;
    localparam int V_ACTIVE = 8;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;

    localparam int LINE_CYCLES  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int FRAME_LINES  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = LINE_CYCLES * FRAME_LINES;
    // whole run plus some margin for reset and pipeline
    localparam int WATCHDOG_CYCLES = RUN_FRAMES * LINE_CYCLES * FRAME_LINES + 100;

    // clock starts low with no edge at time zero
    logic   I_clk = 1'b0;
    logic   rst_n;
    logic   hsync;
    logic   vsync;
    logic   de;
    rgb12_t rgb12;

    // reset delayed by one and two cycles for the model and the reset check
    logic rst_d1 = 1'b0;
    logic rst_d2 = 1'b0;

    // output syncs and de of the previous cycle
    logic hs_prev;
    logic vs_prev;
    logic de_prev;

    // mirrored dither parity
    logic m_col;
    logic m_row;
    logic m_frame;

    // recovered raster position and frame count
    int   px_x;
    int   line_y;
    int   frame_cnt;
    logic frame_pending;

    // sync period and pulse width counters
    int   hs_since;
    int   vs_since;
    logic hs_seen;
    logic vs_seen;
    int   hs_len;
    int   vs_len;
    int   vs_falls;

    logic   hs_rise;
    logic   hs_fall;
    logic   vs_rise;
    logic   vs_fall;
    logic   de_fall;
    int     exp_frame;
    rgb12_t exp_rgb12;

    vga_dither_top #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_dither_top_inst (
        .I_clk (I_clk),
        .rst_n (rst_n),
        .hsync (hsync),
        .vsync (vsync),
        .de    (de),
        .rgb12 (rgb12)
    );

    // 2x2 ordered matrix that swaps on odd frames
    function automatic int threshold_for(input logic odd_frame, input logic row, input logic col);
        int idx;
        int thr;
        idx = (row ? 2 : 0) + (col ? 1 : 0);
        case (idx)
            0:       thr = odd_frame ? 11 : 15;
            1:       thr = odd_frame ? 7 : 3;
            2:       thr = odd_frame ? 3 : 7;
            default: thr = odd_frame ? 15 : 11;
        endcase
        return thr;
    endfunction

    // keep the high nibble and nudge it one step toward the low nibble on a wide spread
    function automatic chan4_t reduce_channel(input int value, input int thr);
        int hi;
        int lo;
        int spread;
        int res;
        hi = (value / 16) % 16;
        lo = value % 16;
        spread = (hi > lo) ? hi - lo : lo - hi;
        if (spread < thr) begin
            res = hi;
        end else if (hi > lo) begin
            res = (hi + 15) % 16;
        end else begin
            res = (hi + 1) % 16;
        end
        return chan4_t'(res);
    endfunction

    // test pattern with red from x, green from x plus y and blue from the frame count
    function automatic rgb12_t expected_colour(input int x, input int y, input int frame,
                                               input int thr);
        chan4_t r;
        chan4_t g;
        chan4_t b;
        r = reduce_channel(x % 256, thr);
        g = reduce_channel((x + y) % 256, thr);
        b = reduce_channel(frame % 256, thr);
        return {r, g, b};
    endfunction

    task automatic report_mismatch(input string check_name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", check_name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1, "check %s failed", check_name);
    endtask

    assign hs_rise = hsync && !hs_prev;
    assign hs_fall = !hsync && hs_prev;
    assign vs_rise = vsync && !vs_prev;
    assign vs_fall = !vsync && vs_prev;
    assign de_fall = !de && de_prev;

    // a frame that has not shown a pixel yet already owns the next count
    always_comb begin
        exp_frame = frame_cnt + (frame_pending ? 1 : 0);
        exp_rgb12 = expected_colour(px_x, line_y, exp_frame,
                                    threshold_for(m_frame, m_row, m_col));
    end

    initial begin
        forever #(CLK_PERIOD / 2) I_clk = ~I_clk;
    end

    always @(posedge I_clk) begin
        rst_d1 <= rst_n;
        rst_d2 <= rst_d1;
    end

    // reference model driven only by the DUT outputs
    always @(posedge I_clk) begin
        if (!rst_d1) begin
            hs_prev       <= 1'b0;
            vs_prev       <= 1'b0;
            de_prev       <= 1'b0;
            m_col         <= 1'b0;
            m_row         <= 1'b0;
            m_frame       <= 1'b0;
            px_x          <= 0;
            line_y        <= 0;
            frame_cnt     <= 0;
            frame_pending <= 1'b1;
            hs_since      <= 0;
            vs_since      <= 0;
            hs_seen       <= 1'b0;
            vs_seen       <= 1'b0;
            hs_len        <= 0;
            vs_len        <= 0;
            vs_falls      <= 0;
        end else begin
            hs_prev <= hsync;
            vs_prev <= vsync;
            de_prev <= de;
            // vsync rise restarts the matrix and otherwise col toggles and row follows hsync
            if (vs_rise) begin
                m_frame <= ~m_frame;
                m_row   <= 1'b0;
                m_col   <= 1'b0;
            end else begin
                m_col <= ~m_col;
                if (hs_rise) begin
                    m_row <= ~m_row;
                end
            end
            px_x <= de ? px_x + 1 : 0;
            if (vsync) begin
                line_y <= 0;
            end else if (de_fall) begin
                line_y <= line_y + 1;
            end
            // first pixel after a vsync pulse opens the next frame
            if (vsync) begin
                frame_pending <= 1'b1;
            end else if (de && frame_pending) begin
                frame_pending <= 1'b0;
                frame_cnt     <= frame_cnt + 1;
            end
            hs_since <= hs_rise ? 1 : hs_since + 1;
            vs_since <= vs_rise ? 1 : vs_since + 1;
            hs_seen  <= hs_seen || hs_rise;
            vs_seen  <= vs_seen || vs_rise;
            hs_len   <= hsync ? hs_len + 1 : 0;
            vs_len   <= vsync ? vs_len + 1 : 0;
            if (vs_fall) begin
                vs_falls <= vs_falls + 1;
            end
        end
    end

    // checks sample at the falling edge halfway between output updates
    check_reset_quiet: assert property (@(negedge I_clk)
        !rst_d2 |-> ({hsync, vsync, de} == 3'b000 && rgb12 == '0))
        else report_mismatch("reset_quiet", 32'd0, 32'({hsync, vsync, de, rgb12}));

    check_hsync_period: assert property (@(negedge I_clk)
        (hs_rise && hs_seen) |-> hs_since == LINE_CYCLES)
        else report_mismatch("hsync_period", LINE_CYCLES, hs_since);

    check_hsync_width: assert property (@(negedge I_clk) hs_fall |-> hs_len == H_SYNC)
        else report_mismatch("hsync_width", H_SYNC, hs_len);

    check_vsync_period: assert property (@(negedge I_clk)
        (vs_rise && vs_seen) |-> vs_since == FRAME_CYCLES)
        else report_mismatch("vsync_period", FRAME_CYCLES, vs_since);

    check_vsync_width: assert property (@(negedge I_clk)
        vs_fall |-> vs_len == V_SYNC * LINE_CYCLES)
        else report_mismatch("vsync_width", V_SYNC * LINE_CYCLES, vs_len);

    check_line_pixels: assert property (@(negedge I_clk) de_fall |-> px_x == H_ACTIVE)
        else report_mismatch("line_pixels", H_ACTIVE, px_x);

    check_frame_lines: assert property (@(negedge I_clk) vs_rise |-> line_y == V_ACTIVE)
        else report_mismatch("frame_lines", V_ACTIVE, line_y);

    check_blank_black: assert property (@(negedge I_clk) !de |-> rgb12 == '0)
        else report_mismatch("blank_black", 32'd0, 32'(rgb12));

    check_pixel_colour: assert property (@(negedge I_clk) de |-> rgb12 == exp_rgb12)
        else report_mismatch("pixel_colour", 32'(exp_rgb12), 32'(rgb12));

    // stimulus is only reset as the raster runs on its own
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge I_clk);
        rst_n <= 1'b1;
        while (vs_falls < RUN_FRAMES) @(posedge I_clk);
        $display("=== PASS ===");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before %0d frames had been seen", RUN_FRAMES);
        $display("=== FAIL ===");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

/* vga_dither_top.f */
rtl/vga_pkg.sv
rtl/vga_timing.sv
rtl/vga_pattern_gen.sv
rtl/vga_dither_channel_8_to_4.sv
rtl/vga_dither_24_to_12.sv
rtl/vga_dither_top.sv
testbench/tb_vga_dither_top.sv
